/* Makefile */
VERILATOR  ?= verilator
TOP        ?= conv_window_tb
RTL_TOP    ?= conv_window_top
FILELIST   ?= conv_window_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/conv_defs.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* conv_window_top.f */
+incdir+design
design/conv_pixel_pkg.sv
design/conv_ctrl_pkg.sv
design/conv_ifs.sv
design/conv_line_bram.sv
design/conv_row_sequencer.sv
design/conv_bram_handler.sv
design/conv_window_top.sv
verif/conv_window_tb.sv

/* design/conv_bram_handler.sv */
`timescale 1ns/1ps

module conv_bram_handler (
  input  logic                       clk,
  input  logic                       reset,
  conv_row_if.handler                row1,
  conv_row_if.handler                row2,
  conv_row_if.handler                row3,
  conv_bram_if.reader                buf1,
  conv_bram_if.reader                buf2,
  conv_bram_if.reader                buf3,
  conv_bram_if.reader_writer         slab1,
  conv_bram_if.reader_writer         slab2,
  conv_bram_if.reader_writer         slab3,
  output logic                       win_valid,
  output conv_pixel_pkg::row_word_t  win_row1,
  output conv_pixel_pkg::row_word_t  win_row2,
  output conv_pixel_pkg::row_word_t  win_row3,
  output conv_pixel_pkg::slab_word_t win_slab1,
  output conv_pixel_pkg::slab_word_t win_slab2,
  output conv_pixel_pkg::slab_word_t win_slab3
);

  localparam int WORD_BITS = $bits(conv_pixel_pkg::row_word_t);
  localparam int SLAB_BITS = $bits(conv_pixel_pkg::slab_word_t);

  conv_ctrl_pkg::bram_adr_t   row_adr [3];
  conv_ctrl_pkg::buf_idx_t    row_buf [3];
  conv_ctrl_pkg::buf_idx_t    row_slab [3];
  logic [2:0]                 row_ws;
  logic [2:0]                 row_vld;

  conv_ctrl_pkg::bram_adr_t   buf_adr [3];
  conv_ctrl_pkg::bram_adr_t   slab_adr [3];
  logic [2:0]                 buf_ws;
  logic [2:0]                 buf_vld;
  logic [2:0]                 slab_vld;

  logic [2:0]                 buf_ws_q;
  logic [2:0]                 buf_vld_q;
  logic [2:0]                 slab_vld_q;
  conv_ctrl_pkg::buf_idx_t    last_buf [3];
  conv_ctrl_pkg::buf_idx_t    last_slab [3];
  conv_ctrl_pkg::bram_adr_t   slab_wr_adr [3];

  conv_pixel_pkg::buf_pair_t  buf_pair [3];
  conv_pixel_pkg::slab_word_t slab_rd [3];
  conv_pixel_pkg::row_word_t  buf_word [3];
  conv_pixel_pkg::slab_word_t slab_word [3];
  conv_pixel_pkg::row_word_t  win_word [3];
  conv_pixel_pkg::slab_word_t win_sl [3];

  assign row_adr[0]  = row1.adr;
  assign row_adr[1]  = row2.adr;
  assign row_adr[2]  = row3.adr;
  assign row_buf[0]  = row1.buf_idx;
  assign row_buf[1]  = row2.buf_idx;
  assign row_buf[2]  = row3.buf_idx;
  assign row_slab[0] = row1.slab_idx;
  assign row_slab[1] = row2.slab_idx;
  assign row_slab[2] = row3.slab_idx;
  assign row_ws      = {row3.word_select, row2.word_select, row1.word_select};
  assign row_vld     = {row3.valid, row2.valid, row1.valid};

  //////////////////////////////
  // cycle 0, logical to physical

  always_comb
  begin
    for (int p = 0; p < 3; p++)
    begin
      buf_adr[p]  = '0;
      buf_ws[p]   = 1'b0;
      buf_vld[p]  = 1'b0;
      slab_adr[p] = '0;
      slab_vld[p] = 1'b0;
      for (int r = 2; r >= 0; r--)
      begin
        if (row_buf[r] == conv_ctrl_pkg::buf_idx_t'(p + 1))
        begin
          buf_adr[p] = row_adr[r];
          buf_ws[p]  = row_ws[r];
          buf_vld[p] = row_vld[r];
        end
        if (row_slab[r] == conv_ctrl_pkg::buf_idx_t'(p + 1))
        begin
          slab_adr[p] = row_adr[r];
          slab_vld[p] = row_vld[r];
        end
      end
    end
  end

  assign buf1.rd_en   = buf_vld[0];
  assign buf2.rd_en   = buf_vld[1];
  assign buf3.rd_en   = buf_vld[2];
  assign buf1.rd_adr  = buf_adr[0];
  assign buf2.rd_adr  = buf_adr[1];
  assign buf3.rd_adr  = buf_adr[2];
  assign slab1.rd_en  = slab_vld[0];
  assign slab2.rd_en  = slab_vld[1];
  assign slab3.rd_en  = slab_vld[2];
  assign slab1.rd_adr = slab_adr[0];
  assign slab2.rd_adr = slab_adr[1];
  assign slab3.rd_adr = slab_adr[2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      buf_ws_q    <= '0;
      buf_vld_q   <= '0;
      slab_vld_q  <= '0;
      last_buf    <= '{default: '0};
      last_slab   <= '{default: '0};
      slab_wr_adr <= '{default: '1};
    end
    else
    begin
      buf_ws_q    <= buf_ws;
      buf_vld_q   <= buf_vld;
      slab_vld_q  <= slab_vld;
      last_buf    <= row_buf;
      last_slab   <= row_slab;
      slab_wr_adr <= buf_adr;
    end
  end

  //////////////////////////////
  // cycle 1, physical back to logical

  assign buf_pair[0] = buf1.rd_data;
  assign buf_pair[1] = buf2.rd_data;
  assign buf_pair[2] = buf3.rd_data;
  assign slab_rd[0]  = slab1.rd_data;
  assign slab_rd[1]  = slab2.rd_data;
  assign slab_rd[2]  = slab3.rd_data;

  always_comb
  begin
    for (int p = 0; p < 3; p++)
    begin
      buf_word[p]  = '0;
      slab_word[p] = '0;
      if (buf_vld_q[p])
      begin
        buf_word[p] = buf_ws_q[p] ? buf_pair[p][2*WORD_BITS-1 -: WORD_BITS]
                                  : buf_pair[p][WORD_BITS-1:0];
      end
      if (slab_vld_q[p])
      begin
        slab_word[p] = slab_rd[p];
      end
    end
    for (int r = 0; r < 3; r++)
    begin
      win_word[r] = '0;
      win_sl[r]   = '0;
      for (int p = 0; p < 3; p++)
      begin
        if (last_buf[r] == conv_ctrl_pkg::buf_idx_t'(p + 1))
        begin
          win_word[r] = buf_word[p];
        end
        if (last_slab[r] == conv_ctrl_pkg::buf_idx_t'(p + 1))
        begin
          win_sl[r] = slab_word[p];
        end
      end
    end
  end

  assign win_valid = |buf_vld_q;
  assign win_row1  = win_word[0];
  assign win_row2  = win_word[1];
  assign win_row3  = win_word[2];
  assign win_slab1 = win_sl[0];
  assign win_slab2 = win_sl[1];
  assign win_slab3 = win_sl[2];

  // slab write-back, leading pixels of the word just read
  assign slab1.wr_en   = buf_vld_q[0];
  assign slab2.wr_en   = buf_vld_q[1];
  assign slab3.wr_en   = buf_vld_q[2];
  assign slab1.wr_adr  = slab_wr_adr[0];
  assign slab2.wr_adr  = slab_wr_adr[1];
  assign slab3.wr_adr  = slab_wr_adr[2];
  assign slab1.wr_data = buf_word[0][WORD_BITS-1 -: SLAB_BITS];
  assign slab2.wr_data = buf_word[1][WORD_BITS-1 -: SLAB_BITS];
  assign slab3.wr_data = buf_word[2][WORD_BITS-1 -: SLAB_BITS];

  // the sequencer requests all three rows together
  a_rows_in_step: assert property (
    @(posedge clk) disable iff (reset)
    (row1.valid == row2.valid) && (row2.valid == row3.valid)
  );

endmodule

/* design/conv_ctrl_pkg.sv */
`include "conv_defs.svh"

package conv_ctrl_pkg;

  typedef logic [`ADR_BITS-1:0] bram_adr_t;

  // 1 to 3 name a physical buffer, 0 is none
  typedef logic [1:0] buf_idx_t;

  // word position within a row
  typedef logic [2:0] word_idx_t;

  typedef enum logic {
    LOAD,
    SWEEP
  } seq_state_t;

endpackage

/* design/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// pixel geometry
`define PIXELS_IN_ROW 8
`define PIXEL_BITS    8

// leading pixels kept per slab entry
`define SLAB_PIXELS   2

// row words per image row, must stay even
`define WORDS_PER_ROW 8

// memory geometry
`define BRAM_DEPTH    16
`define ADR_BITS      16

`endif

/* design/conv_ifs.sv */
`timescale 1ns/1ps

// read request of one logical row
interface conv_row_if;
  conv_ctrl_pkg::bram_adr_t adr;
  logic                     word_select;
  conv_ctrl_pkg::buf_idx_t  buf_idx;
  conv_ctrl_pkg::buf_idx_t  slab_idx;
  logic                     valid;

  modport sequencer (
    output adr,
    output word_select,
    output buf_idx,
    output slab_idx,
    output valid
  );

  modport handler (
    input adr,
    input word_select,
    input buf_idx,
    input slab_idx,
    input valid
  );
endinterface

// simple dual-port memory access
interface conv_bram_if #(
  parameter int DATA_BITS = 16
);
  logic                     rd_en;
  conv_ctrl_pkg::bram_adr_t rd_adr;
  logic [DATA_BITS-1:0]     rd_data;
  logic                     wr_en;
  conv_ctrl_pkg::bram_adr_t wr_adr;
  logic [DATA_BITS-1:0]     wr_data;

  modport memory (input rd_en, rd_adr, wr_en, wr_adr, wr_data, output rd_data);
  modport reader (output rd_en, rd_adr, input rd_data);
  modport writer (output wr_en, wr_adr, wr_data);
  modport reader_writer (output rd_en, rd_adr, wr_en, wr_adr, wr_data, input rd_data);
endinterface

/* design/conv_line_bram.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_line_bram #(
  parameter int DATA_BITS = 16
) (
  input logic         clk,
  conv_bram_if.memory mem
);

  localparam int IDX_BITS = $clog2(`BRAM_DEPTH);

  logic [DATA_BITS-1:0] ram [`BRAM_DEPTH] = '{default: '0};

  // read-first, a colliding read sees the old entry
  always_ff @(posedge clk)
  begin
    if (mem.wr_en)
    begin
      ram[mem.wr_adr[IDX_BITS-1:0]] <= mem.wr_data;
    end
    if (mem.rd_en)
    begin
      mem.rd_data <= ram[mem.rd_adr[IDX_BITS-1:0]];
    end
  end

  // addresses come from the sequencer and handler
  a_wr_in_range: assert property (
    @(posedge clk) mem.wr_en |-> (mem.wr_adr < `BRAM_DEPTH)
  );

  a_rd_in_range: assert property (
    @(posedge clk) mem.rd_en |-> (mem.rd_adr < `BRAM_DEPTH)
  );

endmodule

/* design/conv_pixel_pkg.sv */
`include "conv_defs.svh"

package conv_pixel_pkg;

  // one row word as delivered by the source
  typedef logic [`PIXELS_IN_ROW*`PIXEL_BITS-1:0] row_word_t;

  // even word in the lower half, odd word in the upper half
  typedef logic [2*`PIXELS_IN_ROW*`PIXEL_BITS-1:0] buf_pair_t;

  // leading pixels of a word
  typedef logic [`SLAB_PIXELS*`PIXEL_BITS-1:0] slab_word_t;

endpackage

/* design/conv_row_sequencer.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_row_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_pixel_pkg::row_word_t row_in_data,
  input  logic                      row_in_valid,
  input  logic                      frame_start,
  output logic                      row_in_ready,
  conv_row_if.sequencer             row1,
  conv_row_if.sequencer             row2,
  conv_row_if.sequencer             row3,
  conv_bram_if.writer               buf1,
  conv_bram_if.writer               buf2,
  conv_bram_if.writer               buf3
);

  conv_ctrl_pkg::seq_state_t state;
  conv_ctrl_pkg::word_idx_t  word_cnt;
  logic [1:0]                row_mod;
  logic [1:0]                rows_done;
  conv_pixel_pkg::row_word_t even_word;
  logic [2:0]                wr_en_q;
  conv_ctrl_pkg::bram_adr_t  wr_adr_q;
  conv_pixel_pkg::buf_pair_t wr_data_q;

  logic                      accept;
  logic                      restart;
  logic                      sweeping;
  logic                      row_last;
  conv_ctrl_pkg::word_idx_t  cur_word;
  logic [1:0]                cur_mod;
  logic [1:0]                cur_done;
  conv_ctrl_pkg::buf_idx_t   idx1;
  conv_ctrl_pkg::buf_idx_t   idx2;
  conv_ctrl_pkg::buf_idx_t   idx3;
  conv_ctrl_pkg::bram_adr_t  rd_adr;

  function automatic logic [1:0] mod3_next(input logic [1:0] m);
    return (m == 2'd2) ? 2'd0 : m + 2'd1;
  endfunction

  //////////////////////////////
  // row loading

  assign sweeping     = (state == conv_ctrl_pkg::SWEEP);
  assign row_in_ready = !sweeping;
  assign accept       = row_in_valid && row_in_ready;
  assign restart      = frame_start && !sweeping;

  // a frame start takes effect on the word accepted with it
  assign cur_word = restart ? '0 : word_cnt;
  assign cur_mod  = restart ? '0 : row_mod;
  assign cur_done = restart ? '0 : rows_done;
  assign row_last = (cur_word == conv_ctrl_pkg::word_idx_t'(`WORDS_PER_ROW - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= conv_ctrl_pkg::LOAD;
      word_cnt  <= '0;
      row_mod   <= '0;
      rows_done <= '0;
      wr_en_q   <= '0;
      wr_adr_q  <= '0;
    end
    else
    begin
      wr_en_q <= '0;
      if (sweeping)
      begin
        word_cnt <= word_cnt + 1'b1;
        if (word_cnt == conv_ctrl_pkg::word_idx_t'(`WORDS_PER_ROW - 1))
        begin
          word_cnt <= '0;
          state    <= conv_ctrl_pkg::LOAD;
        end
      end
      else
      begin
        word_cnt  <= cur_word;
        row_mod   <= cur_mod;
        rows_done <= cur_done;
        if (accept)
        begin
          word_cnt <= row_last ? '0 : cur_word + 1'b1;
          if (cur_word[0])
          begin
            wr_en_q[cur_mod] <= 1'b1;
            wr_adr_q         <= conv_ctrl_pkg::bram_adr_t'(cur_word >> 1);
          end
          if (row_last)
          begin
            row_mod <= mod3_next(cur_mod);
            if (cur_done == 2'd2)
              state <= conv_ctrl_pkg::SWEEP;
            else
              rows_done <= cur_done + 2'd1;
          end
        end
      end
    end
  end

  // pair assembly
  always_ff @(posedge clk)
  begin
    if (accept && !cur_word[0])
      even_word <= row_in_data;
    if (accept && cur_word[0])
      wr_data_q <= {row_in_data, even_word};
  end

  assign buf1.wr_en   = wr_en_q[0];
  assign buf2.wr_en   = wr_en_q[1];
  assign buf3.wr_en   = wr_en_q[2];
  assign buf1.wr_adr  = wr_adr_q;
  assign buf2.wr_adr  = wr_adr_q;
  assign buf3.wr_adr  = wr_adr_q;
  assign buf1.wr_data = wr_data_q;
  assign buf2.wr_data = wr_data_q;
  assign buf3.wr_data = wr_data_q;

  //////////////////////////////
  // window sweep

  // row_mod already points past the newest row, i.e. at row k-2
  assign idx1   = sweeping ? conv_ctrl_pkg::buf_idx_t'(row_mod + 2'd1) : '0;
  assign idx2   = sweeping ? conv_ctrl_pkg::buf_idx_t'(mod3_next(row_mod) + 2'd1) : '0;
  assign idx3   = sweeping ? conv_ctrl_pkg::buf_idx_t'(mod3_next(mod3_next(row_mod)) + 2'd1)
                           : '0;
  assign rd_adr = sweeping ? conv_ctrl_pkg::bram_adr_t'(word_cnt >> 1) : '0;

  assign row1.adr         = rd_adr;
  assign row2.adr         = rd_adr;
  assign row3.adr         = rd_adr;
  assign row1.word_select = sweeping && word_cnt[0];
  assign row2.word_select = sweeping && word_cnt[0];
  assign row3.word_select = sweeping && word_cnt[0];
  assign row1.buf_idx     = idx1;
  assign row2.buf_idx     = idx2;
  assign row3.buf_idx     = idx3;
  assign row1.slab_idx    = idx1;
  assign row2.slab_idx    = idx2;
  assign row3.slab_idx    = idx3;
  assign row1.valid       = sweeping;
  assign row2.valid       = sweeping;
  assign row3.valid       = sweeping;

  // input held off for the whole sweep, then released
  a_sweep_backpressure: assert property (
    @(posedge clk) disable iff (reset)
    $rose(sweeping) |-> !row_in_ready [*`WORDS_PER_ROW] ##1 row_in_ready
  );

  a_distinct_buffers: assert property (
    @(posedge clk) disable iff (reset)
    row1.valid |-> (row1.buf_idx != row2.buf_idx) && (row2.buf_idx != row3.buf_idx)
                   && (row1.buf_idx != row3.buf_idx)
  );

endmodule

/* design/conv_window_top.sv */
`timescale 1ns/1ps

module conv_window_top (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_pixel_pkg::row_word_t  row_in_data,
  input  logic                       row_in_valid,
  output logic                       row_in_ready,
  input  logic                       frame_start,
  output logic                       win_valid,
  output conv_pixel_pkg::row_word_t  win_row1,
  output conv_pixel_pkg::row_word_t  win_row2,
  output conv_pixel_pkg::row_word_t  win_row3,
  output conv_pixel_pkg::slab_word_t win_slab1,
  output conv_pixel_pkg::slab_word_t win_slab2,
  output conv_pixel_pkg::slab_word_t win_slab3
);

  localparam int BUF_BITS  = $bits(conv_pixel_pkg::buf_pair_t);
  localparam int SLAB_BITS = $bits(conv_pixel_pkg::slab_word_t);

  conv_row_if row1_if ();
  conv_row_if row2_if ();
  conv_row_if row3_if ();

  conv_bram_if #(.DATA_BITS(BUF_BITS))  buf1_if ();
  conv_bram_if #(.DATA_BITS(BUF_BITS))  buf2_if ();
  conv_bram_if #(.DATA_BITS(BUF_BITS))  buf3_if ();
  conv_bram_if #(.DATA_BITS(SLAB_BITS)) slab1_if ();
  conv_bram_if #(.DATA_BITS(SLAB_BITS)) slab2_if ();
  conv_bram_if #(.DATA_BITS(SLAB_BITS)) slab3_if ();

  conv_row_sequencer row_seq (
    .clk          (clk),
    .reset        (reset),
    .row_in_data  (row_in_data),
    .row_in_valid (row_in_valid),
    .frame_start  (frame_start),
    .row_in_ready (row_in_ready),
    .row1         (row1_if.sequencer),
    .row2         (row2_if.sequencer),
    .row3         (row3_if.sequencer),
    .buf1         (buf1_if.writer),
    .buf2         (buf2_if.writer),
    .buf3         (buf3_if.writer)
  );

  conv_bram_handler bram_xbar (
    .clk       (clk),
    .reset     (reset),
    .row1      (row1_if.handler),
    .row2      (row2_if.handler),
    .row3      (row3_if.handler),
    .buf1      (buf1_if.reader),
    .buf2      (buf2_if.reader),
    .buf3      (buf3_if.reader),
    .slab1     (slab1_if.reader_writer),
    .slab2     (slab2_if.reader_writer),
    .slab3     (slab3_if.reader_writer),
    .win_valid (win_valid),
    .win_row1  (win_row1),
    .win_row2  (win_row2),
    .win_row3  (win_row3),
    .win_slab1 (win_slab1),
    .win_slab2 (win_slab2),
    .win_slab3 (win_slab3)
  );

  // row buffers
  conv_line_bram #(.DATA_BITS(BUF_BITS)) buf_mem1 (.clk(clk), .mem(buf1_if.memory));
  conv_line_bram #(.DATA_BITS(BUF_BITS)) buf_mem2 (.clk(clk), .mem(buf2_if.memory));
  conv_line_bram #(.DATA_BITS(BUF_BITS)) buf_mem3 (.clk(clk), .mem(buf3_if.memory));

  // slabs
  conv_line_bram #(.DATA_BITS(SLAB_BITS)) slab_mem1 (.clk(clk), .mem(slab1_if.memory));
  conv_line_bram #(.DATA_BITS(SLAB_BITS)) slab_mem2 (.clk(clk), .mem(slab2_if.memory));
  conv_line_bram #(.DATA_BITS(SLAB_BITS)) slab_mem3 (.clk(clk), .mem(slab3_if.memory));

endmodule

/* verif/conv_window_tb.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_window_tb;

  localparam int CLK_PERIOD      = 4;
  localparam int WORDS           = `WORDS_PER_ROW;
  localparam int MAX_ROWS        = 6;
  localparam int TOTAL_ROWS      = 6 + 6 + 3;
  localparam int EXPECTED_SWEEPS = (6 - 2) + (6 - 2) + (3 - 2);
  localparam int TIMEOUT_CYCLES  = TOTAL_ROWS * (2 * WORDS + 4) + 100;

  logic                       clk;
  logic                       reset;
  conv_pixel_pkg::row_word_t  row_in_data;
  logic                       row_in_valid;
  logic                       row_in_ready;
  logic                       frame_start;
  logic                       win_valid;
  conv_pixel_pkg::row_word_t  win_row1;
  conv_pixel_pkg::row_word_t  win_row2;
  conv_pixel_pkg::row_word_t  win_row3;
  conv_pixel_pkg::slab_word_t win_slab1;
  conv_pixel_pkg::slab_word_t win_slab2;
  conv_pixel_pkg::slab_word_t win_slab3;

  // reference model state
  conv_pixel_pkg::row_word_t  frame_rows [MAX_ROWS][WORDS];
  conv_pixel_pkg::slab_word_t slab_model [3][WORDS/2];
  int                         word_idx;
  int                         row_idx;
  int                         frame_words;
  int                         sweep_row;
  int                         beat_idx;
  int                         beats_owed;
  int                         sweeps_seen;
  logic                       seen_accept;
  logic                       accept_now;
  logic                       sweep_trigger;

  conv_pixel_pkg::row_word_t  exp_row1;
  conv_pixel_pkg::row_word_t  exp_row2;
  conv_pixel_pkg::row_word_t  exp_row3;
  conv_pixel_pkg::slab_word_t exp_slab1;
  conv_pixel_pkg::slab_word_t exp_slab2;
  conv_pixel_pkg::slab_word_t exp_slab3;

  conv_window_top UUT (
    .clk          (clk),
    .reset        (reset),
    .row_in_data  (row_in_data),
    .row_in_valid (row_in_valid),
    .row_in_ready (row_in_ready),
    .frame_start  (frame_start),
    .win_valid    (win_valid),
    .win_row1     (win_row1),
    .win_row2     (win_row2),
    .win_row3     (win_row3),
    .win_slab1    (win_slab1),
    .win_slab2    (win_slab2),
    .win_slab3    (win_slab3)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic conv_pixel_pkg::slab_word_t leading_pixels(
    input conv_pixel_pkg::row_word_t w
  );
    return w[`PIXELS_IN_ROW*`PIXEL_BITS-1 -: `SLAB_PIXELS*`PIXEL_BITS];
  endfunction

  function automatic conv_pixel_pkg::row_word_t random_word();
    conv_pixel_pkg::row_word_t w;
    logic [31:0]               draw;
    for (int i = 0; i < `PIXELS_IN_ROW; i++)
    begin
      draw = $urandom();
      w[i*`PIXEL_BITS +: `PIXEL_BITS] = draw[`PIXEL_BITS-1:0];
    end
    return w;
  endfunction

  task automatic report_mismatch(input string test, input conv_pixel_pkg::row_word_t expected,
                                 input conv_pixel_pkg::row_word_t actual);
    $display("ERROR %s: expected %h, actual %h", test, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "%s mismatch", test);
  endtask

  task automatic abort_run(input string what);
    $display("=== FAIL ===");
    $fatal(1, "%s", what);
  endtask

  // frame start with valid low, then rows until all words are taken
  task automatic drive_frame(input int rows);
    int target;
    target = rows * WORDS;
    row_in_valid = 1'b0;
    while (!row_in_ready)
    begin
      @(posedge clk);
      #1;
    end
    frame_start = 1'b1;
    @(posedge clk);
    #1;
    frame_start = 1'b0;
    while (frame_words < target)
    begin
      row_in_valid = ($urandom_range(99) < 70);
      row_in_data  = random_word();
      @(posedge clk);
      #1;
    end
    row_in_valid = 1'b0;
  endtask

  //////////////////////////////
  // reference model

  assign accept_now    = row_in_valid && row_in_ready;
  assign sweep_trigger = accept_now && (word_idx == WORDS - 1) && (row_idx >= 2);

  always @(posedge clk)
  begin
    if (reset)
    begin
      word_idx    <= 0;
      row_idx     <= 0;
      frame_words <= 0;
      sweep_row   <= 0;
      beat_idx    <= 0;
      beats_owed  <= 0;
      sweeps_seen <= 0;
      seen_accept <= 1'b0;
      slab_model  <= '{default: '0};
    end
    else
    begin
      if (frame_start && row_in_ready)
      begin
        word_idx    <= 0;
        row_idx     <= 0;
        frame_words <= 0;
      end
      else if (accept_now)
      begin
        frame_rows[row_idx][word_idx] <= row_in_data;
        seen_accept <= 1'b1;
        frame_words <= frame_words + 1;
        word_idx    <= (word_idx == WORDS - 1) ? 0 : word_idx + 1;
        if (word_idx == WORDS - 1)
          row_idx <= row_idx + 1;
        if (sweep_trigger)
          sweep_row <= row_idx;
      end
      beats_owed <= beats_owed + (sweep_trigger ? WORDS : 0) - (win_valid ? 1 : 0);
      if (win_valid)
      begin
        beat_idx <= (beat_idx == WORDS - 1) ? 0 : beat_idx + 1;
        // every buffer takes its odd-word leaders on the last beat
        if (beat_idx == WORDS - 1)
        begin
          sweeps_seen <= sweeps_seen + 1;
          for (int n = 0; n < 3; n++)
            for (int a = 0; a < WORDS/2; a++)
              slab_model[(sweep_row - 2 + n) % 3][a] <=
                leading_pixels(frame_rows[sweep_row - 2 + n][2*a + 1]);
        end
      end
    end
  end

  always_comb
  begin
    exp_row1  = '0;
    exp_row2  = '0;
    exp_row3  = '0;
    exp_slab1 = '0;
    exp_slab2 = '0;
    exp_slab3 = '0;
    if (sweep_row >= 2)
    begin
      exp_row1  = frame_rows[sweep_row - 2][beat_idx];
      exp_row2  = frame_rows[sweep_row - 1][beat_idx];
      exp_row3  = frame_rows[sweep_row][beat_idx];
      exp_slab1 = slab_model[(sweep_row - 2) % 3][beat_idx/2];
      exp_slab2 = slab_model[(sweep_row - 1) % 3][beat_idx/2];
      exp_slab3 = slab_model[sweep_row % 3][beat_idx/2];
    end
  end

  //////////////////////////////
  // checks

  a_reset_state: assert property (@(posedge clk) disable iff (reset)
    !seen_accept |-> row_in_ready && !win_valid)
    else abort_run("ready low or window valid before the first accepted word");

  a_no_early_window: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> beats_owed > 0)
    else abort_run("window beat without a completed third row");

  a_beat_train: assert property (@(posedge clk) disable iff (reset)
    sweep_trigger |-> ##1 !win_valid ##1 win_valid [*`WORDS_PER_ROW] ##1 !win_valid)
    else abort_run("window beats did not follow the completed row");

  a_backpressure: assert property (@(posedge clk) disable iff (reset)
    sweep_trigger |-> ##1 !row_in_ready [*`WORDS_PER_ROW] ##1 row_in_ready)
    else abort_run("row_in_ready not held low for exactly one sweep");

  a_win_row1: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> win_row1 == exp_row1)
    else report_mismatch("window row1", $sampled(exp_row1), $sampled(win_row1));

  a_win_row2: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> win_row2 == exp_row2)
    else report_mismatch("window row2", $sampled(exp_row2), $sampled(win_row2));

  a_win_row3: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> win_row3 == exp_row3)
    else report_mismatch("window row3", $sampled(exp_row3), $sampled(win_row3));

  a_win_slab1: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> win_slab1 == exp_slab1)
    else report_mismatch("window slab1", conv_pixel_pkg::row_word_t'($sampled(exp_slab1)),
                         conv_pixel_pkg::row_word_t'($sampled(win_slab1)));

  a_win_slab2: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> win_slab2 == exp_slab2)
    else report_mismatch("window slab2", conv_pixel_pkg::row_word_t'($sampled(exp_slab2)),
                         conv_pixel_pkg::row_word_t'($sampled(win_slab2)));

  a_win_slab3: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> win_slab3 == exp_slab3)
    else report_mismatch("window slab3", conv_pixel_pkg::row_word_t'($sampled(exp_slab3)),
                         conv_pixel_pkg::row_word_t'($sampled(win_slab3)));

  //////////////////////////////
  // stimulus and watchdog

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    row_in_data  = '0;
    row_in_valid = 1'b0;
    frame_start  = 1'b0;
    void'($urandom(32'h504f));
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    drive_frame(6);
    drive_frame(6);
    drive_frame(3);
    // let the last sweep drain
    while (beats_owed != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    if (sweeps_seen == EXPECTED_SWEEPS)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("=== FAIL ===");
      $fatal(1, "saw %0d sweeps instead of %0d", sweeps_seen, EXPECTED_SWEEPS);
    end
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("=== FAIL ===");
    $fatal(1, "timeout: window stream did not finish");
  end

endmodule
